// File: verif/parser_stimulus.txt
# S <18 data bytes, byte 0 first> <token_pos> <addr> <garbage> <start_lit>
# L <addr> <len> <content bytes, first byte first>   C <addr> <offset> <len>, all hex
S 0841424300440C454647480C494A4B4C0000 8A10 0000 0 0
L 0000 03 414243
L 0003 01 44
L 0004 04 45464748
L 0008 04 494A4B4C
S 290A4E23011D030C616263640101EEEE0000 A508 0010 2 0
C 0010 010A 06
C 0016 0123 14
C 002A 0003 03
C 002D 0003 03
C 0030 0003 03
C 0033 0003 02
L 0035 04 61626364
C 0039 0001 01
C 003A 0001 01
C 003B 0001 01
C 003C 0001 01
S 047172F013808182838485868788898A0000 9000 003D 0 0
L 003D 02 7172
L 003F 0B 808182838485868788898A
S 9091929394959697981CA0A1A2A3EEEE0000 0040 004A 2 1
L 004A 09 909192939495969798
L 0053 04 A0A1A2A3
S A4A5A6A7FE400000B0E5FFF42B01EEEE0000 0950 0057 2 1
L 0057 04 A4A5A6A7
C 005B 0040 40
L 009B 01 B0
C 009C 07FF 05

// File: project.f
+incdir+hdl
hdl/parser_pkg.sv
hdl/token_start_finder.sv
hdl/tag_decoder.sv
hdl/slice_walker.sv
hdl/snappy_token_parser.sv
verif/tb_snappy_token_parser.sv

// File: Bender.yml
package:
  name: snappy_token_parser

sources:
  - target: rtl
    include_dirs:
      - hdl
    files:
      - hdl/parser_pkg.sv
      - hdl/token_start_finder.sv
      - hdl/tag_decoder.sv
      - hdl/slice_walker.sv
      - hdl/snappy_token_parser.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - verif/tb_snappy_token_parser.sv

// File: verif/tb_snappy_token_parser.sv
`timescale 1ns/1ps
`include "parser_params.svh"

/*
 * Testbench for the Snappy token parser
 * drives slices from the stimulus file under random stall and checks every
 * literal piece and copy record against the expected lists
 */
module tb_snappy_token_parser;
	import parser_pkg::*;

	localparam int LIT_BYTES = `PARSER_SLICE_BYTES;
	localparam int DATA_W    = 8 * (`PARSER_SLICE_BYTES + `PARSER_LOOK_BYTES);

	logic        clk;
	logic        rst_n;
	slice_t      slice_i;
	logic        slice_valid_i;
	logic        ready_o;
	logic        stall_i;
	lit_rec_t    lit_o;
	copy_rec_t   copy_o;

	slice_t      slices[$];
	lit_rec_t    exp_lits[$];   // in emission order
	copy_rec_t   exp_copies[$];
	logic        loaded = 1'b0;
	logic [15:0] lfsr;
	logic        bit_a;
	logic        bit_b;

	snappy_token_parser snappy_token_parser_i (
		.clk           (clk),
		.rst_n         (rst_n),
		.slice_i       (slice_i),
		.slice_valid_i (slice_valid_i),
		.ready_o       (ready_o),
		.stall_i       (stall_i),
		.lit_o         (lit_o),
		.copy_o        (copy_o)
	);

	initial clk = 1'b0;
	always #4 clk = ~clk; // 8 ns period

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("Finished with errors");
		$fatal(1, "run stopped at the first error");
	endtask

	// galois lfsr, x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	task automatic load_stimulus();
		int                fd;
		int                n;
		string             line;
		logic [DATA_W-1:0] data;
		logic [15:0]       pos;
		logic [15:0]       addr;
		logic [15:0]       ofs;
		logic [1:0]        garb;
		logic              sl;
		logic [6:0]        len;
		logic [127:0]      body;
		slice_t            s;
		lit_rec_t          l;
		copy_rec_t         c;
		fd = $fopen("verif/parser_stimulus.txt", "r");
		if (fd == 0) begin
			fail_run("could not open verif/parser_stimulus.txt");
		end
		while (!$feof(fd)) begin
			line = "";
			n = $fgets(line, fd);
			if (line.getc(0) == "S") begin
				n = $sscanf(line, "S %h %h %h %h %h", data, pos, addr, garb, sl);
				if (n != 5) fail_run({"bad slice line in stimulus file: ", line});
				s = '{data: data, token_pos: pos, addr: addr, garbage: garb, start_lit: sl};
				slices.push_back(s);
			end else if (line.getc(0) == "L") begin
				n = $sscanf(line, "L %h %h %h", addr, len, body);
				if (n != 3) fail_run({"bad literal line in stimulus file: ", line});
				l.valid = 1'b1;
				l.addr  = addr;
				l.len   = len[4:0];
				l.data  = body << (8 * (LIT_BYTES - int'(len))); // first byte to the top
				exp_lits.push_back(l);
			end else if (line.getc(0) == "C") begin
				n = $sscanf(line, "C %h %h %h", addr, ofs, len);
				if (n != 3) fail_run({"bad copy line in stimulus file: ", line});
				c = '{valid: 1'b1, addr: addr, ofs: ofs, len: len};
				exp_copies.push_back(c);
			end
		end
		$fclose(fd);
	endtask

	task automatic check_lit(input lit_rec_t got, input lit_rec_t exp);
		logic [127:0] mask;
		mask = ~({128{1'b1}} >> (8 * int'(exp.len))); // bytes past the length are don't care
		if (got.addr !== exp.addr)
			fail_run($sformatf("ERR %0t: literal addr expected %h got %h", $time, exp.addr, got.addr));
		if (got.len !== exp.len)
			fail_run($sformatf("ERR %0t: literal len expected %0d got %0d", $time, exp.len, got.len));
		if ((got.data & mask) !== (exp.data & mask))
			fail_run($sformatf("ERR %0t: literal data expected %h got %h", $time,
				exp.data & mask, got.data & mask));
	endtask

	task automatic check_copy(input copy_rec_t got, input copy_rec_t exp);
		if (got.addr !== exp.addr)
			fail_run($sformatf("ERR %0t: copy addr expected %h got %h", $time, exp.addr, got.addr));
		if (got.ofs !== exp.ofs)
			fail_run($sformatf("ERR %0t: copy offset expected %h got %h", $time, exp.ofs, got.ofs));
		if (got.len !== exp.len)
			fail_run($sformatf("ERR %0t: copy len expected %0d got %0d", $time, exp.len, got.len));
	endtask

	initial begin : drive_slices
		rst_n         = 1'b0;
		slice_valid_i = 1'b0;
		slice_i       = '0;
		load_stimulus();
		loaded = 1'b1;
		repeat (8) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);
		if (ready_o !== 1'b1 || lit_o.valid !== 1'b0 || copy_o.valid !== 1'b0) begin
			fail_run("after reset ready_o was not high or a record was already valid");
		end
		foreach (slices[i]) begin
			while (ready_o !== 1'b1) @(negedge clk);
			slice_i       = slices[i];
			slice_valid_i = 1'b1;
			@(negedge clk);
			slice_valid_i = 1'b0;
		end
		while (ready_o !== 1'b1) @(negedge clk); // last slice walked
		repeat (4) @(negedge clk);
		@(posedge clk);
		if (exp_lits.size() != 0 || exp_copies.size() != 0) begin
			fail_run($sformatf("%0d literal and %0d copy records never came out",
				exp_lits.size(), exp_copies.size()));
		end else begin
			$display("Finished with no errors");
			$finish;
		end
	end

	initial begin : drive_stall
		stall_i = 1'b0;
		lfsr    = 16'd87;
		@(posedge rst_n);
		forever begin
			@(negedge clk);
			bit_a   = lfsr[0];
			lfsr    = lfsr_step(lfsr);
			bit_b   = lfsr[0];
			lfsr    = lfsr_step(lfsr);
			stall_i = bit_a & bit_b; // high on about a quarter of the cycles
		end
	end

	// records are one cycle strobes, mid cycle they are stable
	always @(negedge clk) begin : watch_records
		if (rst_n === 1'b1 && lit_o.valid === 1'b1) begin
			if (exp_lits.size() == 0)
				fail_run("a literal record came out that the stimulus file does not list");
			else
				check_lit(lit_o, exp_lits.pop_front());
		end
		if (rst_n === 1'b1 && copy_o.valid === 1'b1) begin
			if (exp_copies.size() == 0)
				fail_run("a copy record came out that the stimulus file does not list");
			else
				check_copy(copy_o, exp_copies.pop_front());
		end
	end

	initial begin : watchdog
		wait (loaded === 1'b1);
		repeat (200 * slices.size() + 1000) @(posedge clk);
		fail_run("timeout: the parser did not finish all slices in time");
	end

endmodule

// File: hdl/snappy_token_parser.sv
`timescale 1ns/1ps
`include "parser_params.svh"

/*
 * Snappy second level token parser
 * walks 16 byte slices and emits literal pieces and copy records
 */
module snappy_token_parser (
	input  logic                  clk,
	input  logic                  rst_n,
	input  parser_pkg::slice_t    slice_i,
	input  logic                  slice_valid_i,
	output logic                  ready_o,
	input  logic                  stall_i,
	output parser_pkg::lit_rec_t  lit_o,
	output parser_pkg::copy_rec_t copy_o
);
	import parser_pkg::*;

	logic [15:0] tok_pos;  // bitmap without the head start
	logic        tok_any;
	logic [3:0]  tok_dist; // bytes to the next token start
	logic [8*(`PARSER_LOOK_BYTES+1)-1:0] tok_head;
	tok_info_t   tok_info;

	token_start_finder token_start_finder_i (
		.pos_i  (tok_pos),
		.any_o  (tok_any),
		.dist_o (tok_dist)
	);

	tag_decoder tag_decoder_i (
		.head_i (tok_head),
		.info_o (tok_info)
	);

	slice_walker slice_walker_i (
		.clk           (clk),
		.rst_n         (rst_n),
		.slice_i       (slice_i),
		.slice_valid_i (slice_valid_i),
		.stall_i       (stall_i),
		.any_i         (tok_any),
		.dist_i        (tok_dist),
		.info_i        (tok_info),
		.pos_o         (tok_pos),
		.head_o        (tok_head),
		.ready_o       (ready_o),
		.lit_o         (lit_o),
		.copy_o        (copy_o)
	);

endmodule

// File: hdl/slice_walker.sv
`timescale 1ns/1ps
`include "parser_params.svh"

/*
 * Slice walker
 * holds one slice, walks it one token per cycle and emits literal pieces
 * and copy records, splitting copies whose offset is below their length
 */
module slice_walker (
	input  logic                                clk,
	input  logic                                rst_n,
	input  parser_pkg::slice_t                  slice_i,
	input  logic                                slice_valid_i,
	input  logic                                stall_i,
	input  logic                                any_i,
	input  logic [3:0]                          dist_i,
	input  parser_pkg::tok_info_t               info_i,
	output logic [15:0]                         pos_o,
	output logic [8*(`PARSER_LOOK_BYTES+1)-1:0] head_o,
	output logic                                ready_o,
	output parser_pkg::lit_rec_t                lit_o,
	output parser_pkg::copy_rec_t               copy_o
);
	import parser_pkg::*;

	localparam int DATA_W = 8 * (`PARSER_SLICE_BYTES + `PARSER_LOOK_BYTES);
	localparam int HEAD_W = 8 * (`PARSER_LOOK_BYTES + 1);
	localparam int LIT_W  = 8 * `PARSER_SLICE_BYTES;
	localparam int ADDR_W = `PARSER_ADDR_W;
	localparam int LEN_W  = `PARSER_LEN_W;
	localparam logic [4:0] FULL = 5'(`PARSER_SLICE_BYTES);

	typedef enum logic [1:0] {ST_IDLE, ST_WALK, ST_SPLIT} state_e;

	state_e            state_q;
	logic [DATA_W-1:0] data_q;       // head byte at the top
	logic [15:0]       pos_q;
	logic [ADDR_W-1:0] addr_q;
	logic [4:0]        remain_q;     // stream bytes left from the head on
	logic              start_lit_q;
	logic              done_q;       // slice is finished once the split ends
	logic [LEN_W-1:0]  split_ofs_q;
	logic [LEN_W-1:0]  split_left_q;

	logic              last_tok;
	logic [4:0]        remain_next;
	logic [4:0]        lead_len;
	logic [4:0]        content_left;
	logic [4:0]        tok_lit_len;
	logic [DATA_W-1:0] tok_body;
	logic              split_last;
	logic [LEN_W-1:0]  piece_len;

	assign ready_o = (state_q == ST_IDLE);
	assign pos_o   = {1'b0, pos_q[14:0]}; // the head start itself does not count
	// zero head outside a real token keeps the decoder quiet
	assign head_o  = (state_q == ST_WALK && !start_lit_q) ? data_q[DATA_W-1 -: HEAD_W] : '0;

	always_comb begin
		last_tok     = !any_i || (remain_q <= {1'b0, dist_i});
		remain_next  = last_tok ? 5'd0 : remain_q - {1'b0, dist_i};
		lead_len     = (any_i && {1'b0, dist_i} < remain_q) ? {1'b0, dist_i} : remain_q;
		content_left = (remain_q > {3'b0, info_i.hdr}) ? remain_q - {3'b0, info_i.hdr} : 5'd0;
		tok_lit_len  = (info_i.len < LEN_W'(content_left)) ? info_i.len[4:0] : content_left;
		tok_body     = data_q << {info_i.hdr, 3'b000}; // literal content after its header
		split_last   = (split_left_q <= split_ofs_q);
		piece_len    = split_last ? split_left_q : split_ofs_q;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state_q      <= ST_IDLE;
			lit_o.valid  <= 1'b0;
			copy_o.valid <= 1'b0;
		end else begin
			lit_o.valid  <= 1'b0; // records are single cycle strobes
			copy_o.valid <= 1'b0;
			case (state_q)
				ST_IDLE: if (slice_valid_i) begin
					data_q      <= slice_i.data;
					pos_q       <= slice_i.token_pos;
					addr_q      <= slice_i.addr;
					start_lit_q <= slice_i.start_lit;
					remain_q    <= FULL - {3'b0, slice_i.garbage};
					state_q     <= ST_WALK;
				end
				ST_WALK: if (!stall_i) begin
					data_q      <= data_q << {dist_i, 3'b000};
					pos_q       <= pos_q << dist_i;
					remain_q    <= remain_next;
					start_lit_q <= 1'b0;
					done_q      <= last_tok;
					state_q     <= last_tok ? ST_IDLE : ST_WALK;
					if (start_lit_q) begin // carried over literal content
						lit_o.valid <= 1'b1;
						lit_o.addr  <= addr_q;
						lit_o.len   <= lead_len;
						lit_o.data  <= data_q[DATA_W-1 -: LIT_W];
						addr_q      <= addr_q + ADDR_W'(lead_len);
					end else begin
						case (info_i.kind)
							TOK_LIT: begin
								lit_o.valid <= (tok_lit_len != 5'd0); // header only at the end
								lit_o.addr  <= addr_q;
								lit_o.len   <= tok_lit_len;
								lit_o.data  <= tok_body[DATA_W-1 -: LIT_W];
								addr_q      <= addr_q + ADDR_W'(tok_lit_len);
							end
							TOK_COPY1, TOK_COPY2: begin
								copy_o.valid <= 1'b1;
								copy_o.addr  <= addr_q;
								copy_o.ofs   <= info_i.ofs;
								if (info_i.overlap) begin
									copy_o.len   <= info_i.ofs[LEN_W-1:0]; // first piece
									addr_q       <= addr_q + ADDR_W'(info_i.ofs[LEN_W-1:0]);
									split_ofs_q  <= info_i.ofs[LEN_W-1:0];
									split_left_q <= info_i.len - info_i.ofs[LEN_W-1:0];
									state_q      <= ST_SPLIT;
								end else begin
									copy_o.len <= info_i.len;
									addr_q     <= addr_q + ADDR_W'(info_i.len);
								end
							end
							default: ; // unsupported tag, skipped
						endcase
					end
				end
				ST_SPLIT: if (!stall_i) begin
					copy_o.valid <= 1'b1; // offset held from the first piece
					copy_o.addr  <= addr_q;
					copy_o.len   <= piece_len;
					addr_q       <= addr_q + ADDR_W'(piece_len);
					split_left_q <= split_left_q - piece_len;
					if (split_last) begin
						state_q <= done_q ? ST_IDLE : ST_WALK;
					end
				end
				default: state_q <= ST_IDLE;
			endcase
		end
	end

	// downstream sees one record per cycle at most
	a_one_record: assert property (@(posedge clk) disable iff (!rst_n)
		!(lit_o.valid && copy_o.valid));

	// a stall cycle is always followed by a quiet output
	a_stall_quiet: assert property (@(posedge clk) disable iff (!rst_n)
		stall_i |=> !lit_o.valid && !copy_o.valid);

endmodule

// File: hdl/tag_decoder.sv
`timescale 1ns/1ps
`include "parser_params.svh"

/*
 * Snappy tag decoder
 * reads the head tag and its two following bytes and returns token kind,
 * header size, length, offset and the overlap flag, purely combinational
 */
module tag_decoder (
	input  logic [8*(`PARSER_LOOK_BYTES+1)-1:0] head_i,
	output parser_pkg::tok_info_t               info_o
);
	import parser_pkg::*;

	localparam int HEAD_W = 8 * (`PARSER_LOOK_BYTES + 1);
	localparam int LEN_W  = `PARSER_LEN_W;
	localparam int OFS_W  = `PARSER_OFS_W;

	tag_u       tag;
	logic [7:0] b1; // first byte after the tag
	logic [7:0] b2;

	// a slice never holds more than 16 content bytes, so long lengths saturate
	function automatic logic [LEN_W-1:0] clip_len(input logic [16:0] n);
		return (|n[16:LEN_W]) ? '1 : n[LEN_W-1:0];
	endfunction

	assign tag = head_i[HEAD_W-1 -: 8];
	assign b1  = head_i[HEAD_W-9 -: 8];
	assign b2  = head_i[HEAD_W-17 -: 8];

	always_comb begin
		info_o      = '0;
		info_o.kind = TOK_BAD;
		info_o.hdr  = 2'd1;
		case (tag.lit.kind)
			TOK_LIT: begin
				if (tag.lit.len < 6'(`PARSER_LIT_LONG1)) begin
					info_o.kind = TOK_LIT;
					info_o.len  = LEN_W'(tag.lit.len) + 1'b1;
				end else if (tag.lit.len == 6'(`PARSER_LIT_LONG1)) begin
					info_o.kind = TOK_LIT;
					info_o.hdr  = 2'd2;
					info_o.len  = clip_len({9'd0, b1} + 17'd1);
				end else if (tag.lit.len == 6'(`PARSER_LIT_LONG2)) begin
					info_o.kind = TOK_LIT;
					info_o.hdr  = 2'd3;
					info_o.len  = clip_len({1'b0, b2, b1} + 17'd1); // little endian
				end
			end
			TOK_COPY1: begin
				info_o.kind = TOK_COPY1;
				info_o.hdr  = 2'd2;
				info_o.len  = LEN_W'(tag.copy1.len) + LEN_W'(4);
				info_o.ofs  = OFS_W'({tag.copy1.ofs_hi, b1}); // 11 bit offset
			end
			TOK_COPY2: begin
				info_o.kind = TOK_COPY2;
				info_o.hdr  = 2'd3;
				info_o.len  = LEN_W'(tag.copy2.len) + 1'b1;
				info_o.ofs  = {b2, b1};
			end
			default: ; // four byte offset copy stays bad
		endcase

		// source runs into bytes the copy itself writes
		info_o.overlap = (info_o.kind inside {TOK_COPY1, TOK_COPY2}) &&
			(info_o.ofs != '0) && (info_o.ofs < OFS_W'(info_o.len));
	end

	// the first level parser never hands over the unsupported forms
	// an unknown head before the walker leaves reset is not a tag
	a_supported_tag: assert final ($isunknown(tag) || info_o.kind != TOK_BAD)
		else $error("unsupported snappy tag %h", tag);

endmodule

// File: hdl/token_start_finder.sv
`timescale 1ns/1ps

/*
 * Token start finder
 * two level priority encoder over the 16 bit token bitmap, returns the
 * byte distance from the top to the first set bit
 */
module token_start_finder (
	input  logic [15:0] pos_i,
	output logic        any_o,
	output logic [3:0]  dist_o
);

	logic [2:0] nib [4]; // {found, index from msb} per nibble, nibble 0 on top
	logic [2:0] top;

	// four bit encoder, index counted from the msb
	function automatic logic [2:0] penc4(input logic [3:0] x);
		logic [1:0] idx;
		idx[1] = ~(x[3] | x[2]);
		idx[0] = ~(x[3] | (~x[2] & x[1]));
		return {|x, idx};
	endfunction

	always_comb begin
		for (int i = 0; i < 4; i++) begin
			nib[i] = penc4(pos_i[15-4*i -: 4]);
		end
		// second level picks the first nibble that has a start
		top = penc4({nib[0][2], nib[1][2], nib[2][2], nib[3][2]});
	end

	assign any_o  = top[2];
	assign dist_o = {top[1:0], nib[top[1:0]][1:0]};

endmodule

// File: hdl/parser_pkg.sv
/*
 * Snappy token parser types
 * input slice, tag byte views, decoded token and the two output records
 */
`include "parser_params.svh"

package parser_pkg;

	typedef struct packed {
		logic [8*(`PARSER_SLICE_BYTES+`PARSER_LOOK_BYTES)-1:0] data; // byte 0 at the top
		logic [`PARSER_SLICE_BYTES-1:0] token_pos; // bit 15 is byte 0
		logic [`PARSER_ADDR_W-1:0] addr;
		logic [1:0] garbage;   // trailing bytes that are not part of the stream
		logic start_lit;       // slice opens with literal content from the last slice
	} slice_t;

	// the same tag byte read three ways, kind bits always at the bottom
	typedef union packed {
		struct packed {logic [5:0] len; logic [1:0] kind;} lit;
		struct packed {logic [2:0] ofs_hi; logic [2:0] len; logic [1:0] kind;} copy1;
		struct packed {logic [5:0] len; logic [1:0] kind;} copy2;
	} tag_u;

	typedef enum logic [1:0] {
		TOK_LIT   = 2'b00,
		TOK_COPY1 = 2'b01,
		TOK_COPY2 = 2'b10,
		TOK_BAD   = 2'b11  // 62/63 literal forms and four byte offset copies
	} tok_kind_e;

	typedef struct packed {
		tok_kind_e kind;
		logic [1:0] hdr;                // header bytes, 1 to 3
		logic [`PARSER_LEN_W-1:0] len;  // clipped for long literals
		logic [`PARSER_OFS_W-1:0] ofs;
		logic overlap;                  // copy source overlaps its destination
	} tok_info_t;

	typedef struct packed {
		logic valid;
		logic [`PARSER_ADDR_W-1:0] addr;
		logic [4:0] len;                           // 1 to 16
		logic [8*`PARSER_SLICE_BYTES-1:0] data;    // first byte at the top
	} lit_rec_t;

	typedef struct packed {
		logic valid;
		logic [`PARSER_ADDR_W-1:0] addr;
		logic [`PARSER_OFS_W-1:0] ofs;
		logic [`PARSER_LEN_W-1:0] len;
	} copy_rec_t;

endpackage

// File: hdl/parser_params.svh
/*
 * Snappy token parser parameters
 * slice geometry, field widths and the long literal length codes
 */
`ifndef PARSER_PARAMS_SVH
`define PARSER_PARAMS_SVH

// slice geometry
`define PARSER_SLICE_BYTES 16 // valid bytes per slice
`define PARSER_LOOK_BYTES 2   // extra bytes so a 3 byte tag at byte 15 can be read

// field widths
`define PARSER_ADDR_W 16 // output byte address
`define PARSER_LEN_W 7   // copy lengths go up to 64
`define PARSER_OFS_W 16  // copy offset

// literal length codes that pull the length from the following bytes
`define PARSER_LIT_LONG1 60 // one length byte follows
`define PARSER_LIT_LONG2 61 // two length bytes follow, little endian

`endif
